/* hw/l2_pkg.sv */
package l2_pkg;

    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;
    localparam int OFFSET_W = 2;                       // word select inside a line
    localparam int INDEX_W  = 4;
    localparam int WAYS     = 8;
    localparam int WAY_W    = 3;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W - 2;
    localparam int LINE_W   = WORD_W << OFFSET_W;      // 128
    localparam int SETS     = 1 << INDEX_W;

    // one cache line, word 0 in the low bits
    typedef logic [(1 << OFFSET_W)-1:0][WORD_W-1:0] line_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    // request source, codes as seen on the old from bus
    typedef enum logic [1:0] {
        SRC_NONE   = 2'b00,
        SRC_IREAD  = 2'b01,
        SRC_DREAD  = 2'b10,
        SRC_DWRITE = 2'b11
    } src_e;

endpackage

/* hw/way_ram.sv */
module way_ram #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 16
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    // all zero after reset, so every tag entry starts invalid
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];   // async read

endmodule

/* hw/plru_table.sv */
module plru_table (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [l2_pkg::INDEX_W-1:0] index,
    input  logic                       use_valid,
    input  logic [l2_pkg::WAY_W-1:0]   use_way,
    output logic [l2_pkg::WAY_W-1:0]   victim
);
    import l2_pkg::*;

    // heap order: node 1 is the root, node n has children 2n and 2n+1
    logic [WAYS-1:1] tree [SETS];
    logic [WAYS-1:1] next_bits;

    // walk from the root, each bit picks the side to evict
    always_comb begin : pick
        int node;
        node = 1;
        for (int l = 0; l < WAY_W; l++) begin
            node = 2 * node + int'(tree[index][node]);
        end
        victim = WAY_W'(node - WAYS);
    end

    // bits on the path of the used way point the other way
    always_comb begin : touch
        int node;
        node = 1;
        next_bits = tree[index];
        for (int l = WAY_W - 1; l >= 0; l--) begin
            next_bits[node] = ~use_way[l];
            node = 2 * node + int'(use_way[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (use_valid) begin
            tree[index] <= next_bits;
        end
    end

endmodule

/* hw/tag_dirty_store.sv */
module tag_dirty_store (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [l2_pkg::INDEX_W-1:0] index,
    input  logic [l2_pkg::TAG_W-1:0]   tag,
    input  logic                       tag_we,
    input  logic [l2_pkg::WAY_W-1:0]   tag_way,
    input  logic                       dirty_set,
    input  logic                       dirty_clr,
    input  logic [l2_pkg::WAY_W-1:0]   dirty_way,
    input  logic [l2_pkg::WAY_W-1:0]   victim,
    output logic [l2_pkg::WAYS-1:0]    hit,
    output logic                       victim_dirty,
    output logic [l2_pkg::TAG_W-1:0]   victim_tag
);
    import l2_pkg::*;

    tag_entry_t      rd_entry [WAYS];
    tag_entry_t      new_entry;
    logic [WAYS-1:0] dirty [SETS];

    assign new_entry = '{valid: 1'b1, tag: tag};   // a written tag is always valid

    ////////////////////////////////////////////////////////////////////////
    // tag arrays and compare
    ////////////////////////////////////////////////////////////////////////
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        way_ram #(
            .entry_t (tag_entry_t),
            .DEPTH   (SETS)
        ) u_tag (
            .clk,
            .rstn,
            .we    (tag_we && (tag_way == WAY_W'(w))),
            .waddr (index),
            .wdata (new_entry),
            .raddr (index),
            .rdata (rd_entry[w])
        );

        assign hit[w] = rd_entry[w].valid && (rd_entry[w].tag == tag);
    end

    ////////////////////////////////////////////////////////////////////////
    // dirty bits
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                dirty[s] <= '0;
            end
        end else if (dirty_set) begin
            dirty[index][dirty_way] <= 1'b1;
        end else if (dirty_clr) begin
            dirty[index][dirty_way] <= 1'b0;   // clean refill
        end
    end

    // victim state for the write-back decision and address
    assign victim_dirty = dirty[index][victim];
    assign victim_tag   = rd_entry[victim].tag;

endmodule

/* hw/line_store.sv */
module line_store (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [l2_pkg::INDEX_W-1:0]  index,
    input  logic [l2_pkg::OFFSET_W-1:0] word,
    input  logic [l2_pkg::WAY_W-1:0]    way,
    input  logic                        refill,
    input  l2_pkg::line_t               refill_line,
    input  logic                        word_we,
    input  logic [l2_pkg::WORD_W-1:0]   wdata,
    output logic [l2_pkg::WORD_W-1:0]   rdata,
    output l2_pkg::line_t               line_out
);
    import l2_pkg::*;

    line_t rd_line [WAYS];
    line_t merged;
    line_t wline;

    // one word replaced in the line already held
    always_comb begin
        merged = rd_line[way];
        merged[word] = wdata;
    end

    assign wline = refill ? refill_line : merged;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        way_ram #(
            .entry_t (line_t),
            .DEPTH   (SETS)
        ) u_data (
            .clk,
            .rstn,
            .we    ((refill || word_we) && (way == WAY_W'(w))),
            .waddr (index),
            .wdata (wline),
            .raddr (index),
            .rdata (rd_line[w])
        );
    end

    assign line_out = rd_line[way];   // also the write-back data
    assign rdata    = line_out[word];

endmodule

/* hw/req_buffer.sv */
module req_buffer (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        load,
    input  l2_pkg::src_e                src,
    input  logic [l2_pkg::ADDR_W-1:0]   addr,
    input  logic [l2_pkg::WORD_W-1:0]   wdata,
    output l2_pkg::src_e                src_q,
    output logic [l2_pkg::TAG_W-1:0]    tag,
    output logic [l2_pkg::INDEX_W-1:0]  index,
    output logic [l2_pkg::OFFSET_W-1:0] word,
    output logic [l2_pkg::WORD_W-1:0]   wdata_q
);
    import l2_pkg::*;

    logic [ADDR_W-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            src_q <= SRC_NONE;
        end else if (load) begin
            src_q <= src;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    // tag | index | word | byte
    assign tag   = addr_q[ADDR_W-1 -: TAG_W];
    assign index = addr_q[OFFSET_W + 2 +: INDEX_W];
    assign word  = addr_q[2 +: OFFSET_W];

endmodule

/* hw/main_fsm.sv */
module main_fsm (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     icache_req,
    input  logic                     dcache_req,
    input  logic                     dcache_wr,
    input  l2_pkg::src_e             src_q,
    input  logic [l2_pkg::WAYS-1:0]  hit,
    input  logic [l2_pkg::WAY_W-1:0] victim,
    input  logic                     victim_dirty,
    input  logic                     mem_addr_ok_r,
    input  logic                     mem_addr_ok_w,
    input  logic                     mem_data_ok,
    output logic                     load,
    output l2_pkg::src_e             src,
    output logic                     icache_addr_ok,
    output logic                     dcache_addr_ok,
    output logic                     icache_data_ok,
    output logic                     dcache_data_ok,
    output logic                     mem_req_r,
    output logic                     mem_req_w,
    output logic                     mem_rdy,
    output logic                     tag_we,
    output logic                     dirty_set,
    output logic                     dirty_clr,
    output logic                     refill,
    output logic                     word_we,
    output logic                     use_valid,
    output logic [l2_pkg::WAY_W-1:0] way,
    output logic                     data_sel_return
);
    import l2_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL_REQ,
        REFILL_WAIT,
        REFILL_MERGE
    } state_e;

    state_e           state;
    state_e           next_state;
    logic [WAY_W-1:0] hit_pos;
    logic [WAY_W-1:0] victim_q;
    logic             any_hit;
    logic             is_write;

    assign any_hit  = |hit;
    assign is_write = (src_q == SRC_DWRITE);

    // data side wins a tie
    always_comb begin
        if (dcache_req) begin
            src = dcache_wr ? SRC_DWRITE : SRC_DREAD;
        end else if (icache_req) begin
            src = SRC_IREAD;
        end else begin
            src = SRC_NONE;
        end
    end

    // lowest hitting way
    always_comb begin
        hit_pos = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (hit[w]) begin
                hit_pos = WAY_W'(w);
            end
        end
    end

    // victim is fixed once the miss is seen
    assign way = (state == LOOKUP) ? (any_hit ? hit_pos : victim) : victim_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= IDLE;
            victim_q <= '0;
        end else begin
            state <= next_state;
            if (state == LOOKUP && !any_hit) begin
                victim_q <= victim;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state and strobes
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        next_state      = state;
        load            = 1'b0;
        icache_addr_ok  = 1'b0;
        dcache_addr_ok  = 1'b0;
        icache_data_ok  = 1'b0;
        dcache_data_ok  = 1'b0;
        mem_req_r       = 1'b0;
        mem_req_w       = 1'b0;
        mem_rdy         = 1'b0;
        tag_we          = 1'b0;
        dirty_set       = 1'b0;
        dirty_clr       = 1'b0;
        refill          = 1'b0;
        word_we         = 1'b0;
        use_valid       = 1'b0;
        data_sel_return = 1'b0;
        case (state)
            IDLE: begin
                if (src != SRC_NONE) begin
                    load           = 1'b1;
                    icache_addr_ok = (src == SRC_IREAD);
                    dcache_addr_ok = src[1];   // both data codes
                    next_state     = LOOKUP;
                end
            end
            LOOKUP: begin
                if (any_hit) begin
                    use_valid      = 1'b1;
                    word_we        = is_write;   // write hit, merge and mark dirty
                    dirty_set      = is_write;
                    icache_data_ok = (src_q == SRC_IREAD);
                    dcache_data_ok = (src_q == SRC_DREAD);
                    next_state     = IDLE;
                end else if (victim_dirty) begin
                    next_state = WRITEBACK;
                end else begin
                    next_state = REFILL_REQ;
                end
            end
            WRITEBACK: begin
                mem_req_w = 1'b1;
                if (mem_addr_ok_w) begin
                    next_state = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                mem_req_r = 1'b1;
                if (mem_addr_ok_r) begin
                    next_state = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                mem_rdy = 1'b1;
                if (mem_data_ok) begin
                    refill    = 1'b1;
                    tag_we    = 1'b1;
                    use_valid = 1'b1;
                    dirty_set = is_write;
                    dirty_clr = !is_write;
                    if (is_write) begin
                        next_state = REFILL_MERGE;
                    end else begin
                        data_sel_return = 1'b1;   // word straight from the bus
                        icache_data_ok  = (src_q == SRC_IREAD);
                        dcache_data_ok  = (src_q == SRC_DREAD);
                        next_state      = IDLE;
                    end
                end
            end
            REFILL_MERGE: begin
                word_we    = 1'b1;
                next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

endmodule

/* hw/l2_cache.sv */
module l2_cache (
    input  logic                      clk,
    input  logic                      rstn,
    // instruction client
    input  logic                      icache_req,
    input  logic [l2_pkg::ADDR_W-1:0] icache_addr,
    output logic                      icache_addr_ok,
    output logic                      icache_data_ok,
    output logic [l2_pkg::WORD_W-1:0] icache_rdata,
    // data client
    input  logic                      dcache_req,
    input  logic                      dcache_wr,
    input  logic [l2_pkg::ADDR_W-1:0] dcache_addr,
    input  logic [l2_pkg::WORD_W-1:0] dcache_wdata,
    output logic                      dcache_addr_ok,
    output logic                      dcache_data_ok,
    output logic [l2_pkg::WORD_W-1:0] dcache_rdata,
    // memory, whole lines
    output logic                      mem_req_r,
    output logic [l2_pkg::ADDR_W-1:0] mem_raddr,
    input  logic                      mem_addr_ok_r,
    output logic                      mem_rdy,
    input  logic                      mem_data_ok,
    input  l2_pkg::line_t             mem_rdata,
    output logic                      mem_req_w,
    output logic [l2_pkg::ADDR_W-1:0] mem_waddr,
    output l2_pkg::line_t             mem_wdata,
    input  logic                      mem_addr_ok_w
);
    import l2_pkg::*;

    src_e                src;
    src_e                src_q;
    logic                load;
    logic [ADDR_W-1:0]   req_addr;
    logic [TAG_W-1:0]    tag;
    logic [TAG_W-1:0]    victim_tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] word;
    logic [WORD_W-1:0]   wdata_q;
    logic [WORD_W-1:0]   store_word;
    logic [WORD_W-1:0]   rdata;
    logic [WAYS-1:0]     hit;
    logic [WAY_W-1:0]    victim;
    logic [WAY_W-1:0]    way;
    logic                victim_dirty;
    logic                tag_we;
    logic                dirty_set;
    logic                dirty_clr;
    logic                refill;
    logic                word_we;
    logic                use_valid;
    logic                data_sel_return;

    assign req_addr  = src[1] ? dcache_addr : icache_addr;
    assign mem_raddr = {tag, index, {(OFFSET_W + 2){1'b0}}};         // line aligned
    assign mem_waddr = {victim_tag, index, {(OFFSET_W + 2){1'b0}}};

    assign rdata        = data_sel_return ? mem_rdata[word] : store_word;
    assign icache_rdata = rdata;
    assign dcache_rdata = rdata;

    main_fsm u_fsm (
        .clk, .rstn, .icache_req, .dcache_req, .dcache_wr, .src_q, .hit, .victim,
        .victim_dirty, .mem_addr_ok_r, .mem_addr_ok_w, .mem_data_ok, .load, .src,
        .icache_addr_ok, .dcache_addr_ok, .icache_data_ok, .dcache_data_ok,
        .mem_req_r, .mem_req_w, .mem_rdy, .tag_we, .dirty_set, .dirty_clr,
        .refill, .word_we, .use_valid, .way, .data_sel_return
    );

    req_buffer u_rbuf (
        .clk, .rstn, .load, .src, .addr(req_addr), .wdata(dcache_wdata),
        .src_q, .tag, .index, .word, .wdata_q
    );

    tag_dirty_store u_tags (
        .clk, .rstn, .index, .tag, .tag_we, .tag_way(way), .dirty_set, .dirty_clr,
        .dirty_way(way), .victim(way), .hit, .victim_dirty, .victim_tag
    );

    line_store u_lines (
        .clk, .rstn, .index, .word, .way, .refill, .refill_line(mem_rdata),
        .word_we, .wdata(wdata_q), .rdata(store_word), .line_out(mem_wdata)
    );

    plru_table u_plru (
        .clk, .rstn, .index, .use_valid, .use_way(way), .victim
    );

endmodule

/* tests/mem_model.sv */
module mem_model (
    input  logic                      clk,
    input  logic                      mem_req_r,
    input  logic [l2_pkg::ADDR_W-1:0] mem_raddr,
    output logic                      mem_addr_ok_r,
    input  logic                      mem_rdy,
    output logic                      mem_data_ok,
    output l2_pkg::line_t             mem_rdata,
    input  logic                      mem_req_w,
    input  logic [l2_pkg::ADDR_W-1:0] mem_waddr,
    input  l2_pkg::line_t             mem_wdata,
    output logic                      mem_addr_ok_w
);
    import l2_pkg::*;

    line_t             store [logic [ADDR_W-1:0]];   // sparse, keyed by line address
    logic [ADDR_W-1:0] raddr_q;

    // initial content, depends on every address bit
    function automatic logic [WORD_W-1:0] init_word(input logic [ADDR_W-1:0] a);
        return {a[15:0], ~a[31:16]} ^ 32'h3c3c_a5a5;
    endfunction

    function automatic line_t read_line(input logic [ADDR_W-1:0] a);
        line_t l;
        if (store.exists(a)) return store[a];
        for (int k = 0; k < 4; k++) l[k] = init_word(a + ADDR_W'(4 * k));
        return l;
    endfunction

    initial begin
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rdata     = '0;
        forever begin
            @(negedge clk);
            if (mem_req_w) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);
                mem_addr_ok_w = 1'b1;
                store[mem_waddr] = mem_wdata;
                @(negedge clk);
                mem_addr_ok_w = 1'b0;
            end else if (mem_req_r) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);
                mem_addr_ok_r = 1'b1;
                raddr_q = mem_raddr;
                @(negedge clk);
                mem_addr_ok_r = 1'b0;
                repeat ($urandom_range(0, 3)) @(negedge clk);
                mem_rdata   = read_line(raddr_q);
                mem_data_ok = 1'b1;
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

endmodule

/* tests/tb_l2_cache.sv */
module tb_l2_cache;
    import l2_pkg::*;

    logic clk, rstn;
    logic icache_req, icache_addr_ok, icache_data_ok;
    logic dcache_req, dcache_wr, dcache_addr_ok, dcache_data_ok;
    logic [ADDR_W-1:0] icache_addr, dcache_addr, mem_raddr, mem_waddr;
    logic [WORD_W-1:0] icache_rdata, dcache_rdata, dcache_wdata;
    logic mem_req_r, mem_addr_ok_r, mem_rdy, mem_data_ok, mem_req_w, mem_addr_ok_w;
    line_t mem_rdata, mem_wdata;

    logic [WORD_W-1:0] shadow [logic [ADDR_W-1:0]];
    logic [WORD_W-1:0] exp_i [$];
    logic [WORD_W-1:0] exp_d [$];
    logic [ADDR_W-1:0] last_raddr;
    int cyc, issued, errors, refills, wbs, d_ok_cyc, i_ok_cyc, d_lat;

    l2_cache uut (.*);
    mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [WORD_W-1:0] ref_word(input logic [ADDR_W-1:0] a);
        if (shadow.exists(a)) return shadow[a];
        return u_mem.init_word(a);
    endfunction

    task automatic check(input string name, input logic [LINE_W-1:0] got,
                         input logic [LINE_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // compare process, sampled before the edge updates
    ////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rstn) begin
            if (dcache_req && dcache_addr_ok) begin
                d_ok_cyc = cyc;
                if (dcache_wr) shadow[dcache_addr] = dcache_wdata;
                else exp_d.push_back(ref_word(dcache_addr));
            end
            if (icache_req && icache_addr_ok) begin
                i_ok_cyc = cyc;
                exp_i.push_back(ref_word(icache_addr));
            end
            if (dcache_data_ok) begin
                d_lat = cyc - d_ok_cyc;
                check("dcache_rdata", dcache_rdata, exp_d.pop_front());
            end
            if (icache_data_ok) check("icache_rdata", icache_rdata, exp_i.pop_front());
            if (mem_req_r && mem_addr_ok_r) begin
                refills++;
                last_raddr = mem_raddr;
            end
            if (mem_data_ok) check("mem_rdy", mem_rdy, 1'b1);   // line only while waiting
            if (mem_req_w && mem_addr_ok_w) begin
                wbs++;
                for (int k = 0; k < 4; k++)
                    check("mem_wdata", mem_wdata[k], ref_word(mem_waddr + ADDR_W'(4 * k)));
            end
        end
    end

    task automatic d_access(input logic wr, input logic [ADDR_W-1:0] a,
                            input logic [WORD_W-1:0] d);
        @(negedge clk);
        issued++;
        dcache_req = 1'b1;
        dcache_wr = wr;
        dcache_addr = a;
        dcache_wdata = d;
        forever begin
            @(posedge clk);
            if (dcache_addr_ok) break;
        end
        @(negedge clk);
        dcache_req = 1'b0;
        if (!wr) while (exp_d.size() != 0) @(negedge clk);
    endtask

    task automatic i_read(input logic [ADDR_W-1:0] a);
        @(negedge clk);
        issued++;
        icache_req = 1'b1;
        icache_addr = a;
        forever begin
            @(posedge clk);
            if (icache_addr_ok) break;
        end
        @(negedge clk);
        icache_req = 1'b0;
        while (exp_i.size() != 0) @(negedge clk);
    endtask

    // watchdog, budget grows with every request issued
    initial begin
        forever begin
            @(posedge clk);
            if (cyc > 200 * (issued + 1)) begin
                $display("timeout: the cache stopped answering requests");
                $display("Some tests failed");
                $fatal(1);
            end
        end
    end

    initial begin
        int n;
        void'($urandom(65));
        {issued, errors, refills, wbs, d_lat} = '0;
        {icache_req, dcache_req, dcache_wr} = '0;
        {icache_addr, dcache_addr, dcache_wdata} = '0;
        rstn = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        d_access(1'b0, 32'h0000_1004, '0);   // cold miss
        check("mem_raddr", last_raddr, 32'h0000_1000);
        n = refills;
        d_access(1'b0, 32'h0000_1008, '0);
        check("hit latency", d_lat, 1);
        check("refills", refills, n);

        d_access(1'b1, 32'h0000_1008, 32'hdead_beef);
        d_access(1'b0, 32'h0000_1008, '0);
        d_access(1'b1, 32'h2000_0014, 32'h1234_5678);   // write miss
        d_access(1'b0, 32'h2000_0014, '0);

        n = wbs;
        for (int t = 1; t <= 9; t++) d_access(1'b1, (t << 8) | 32'h54, 32'hab00_0000 | t);
        for (int t = 1; t <= 9; t++) d_access(1'b0, (t << 8) | 32'h54, '0);
        if (wbs == n) check("dirty evictions", wbs, n + 1);

        // both clients in one cycle
        fork
            i_read(32'h0000_3030);
            d_access(1'b0, 32'h0000_4040, '0);
        join
        if (d_ok_cyc >= i_ok_cyc) check("addr_ok order", i_ok_cyc, d_ok_cyc + 1);

        for (int i = 0; i < 400; i++) begin
            logic [ADDR_W-1:0] a;
            a = {TAG_W'($urandom_range(0, 11)), 4'(2 + 5 * $urandom_range(0, 2)),
                 2'($urandom), 2'b00};
            case ($urandom_range(0, 2))
                0: i_read(a);
                1: d_access(1'b0, a, '0);
                default: d_access(1'b1, a, $urandom);
            endcase
        end
        repeat (4) @(posedge clk);

        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/l2_pkg.sv
hw/way_ram.sv
hw/plru_table.sv
hw/tag_dirty_store.sv
hw/line_store.sv
hw/req_buffer.sv
hw/main_fsm.sv
hw/l2_cache.sv
tests/mem_model.sv
tests/tb_l2_cache.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module tb_l2_cache -f filelist.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
